// ==== Bender.yml ====
package:
  name: radiationProcessor

sources:
  - common/radiationRegPkg.sv
  - common/radiationBufferPkg.sv
  - logic/hostRegisters.sv
  - playback/sampleBuffer.sv
  - playback/playbackScheduler.sv
  - logic/refillRequester.sv
  - logic/processingTimer.sv
  - logic/radiationProcessor.sv
  - target: test
    files:
      - verif/radiationProcessor_assert.sv
      - verif/radiationProcessorTb.sv

// ==== common/radiationBufferPkg.sv ====
// sample buffer sizes, sample layout, counters
// and playback constants
package radiationBufferPkg;

    // buffer geometry
    localparam int bufferAddrWidth = 14;
    localparam int bufferDepth = 16384;

    // both halves of a stored sample
    localparam int fieldWidth = 16;
    // value bits presented at the output
    localparam int valueWidth = 10;
    // counters and timer
    localparam int countWidth = 32;

    // one memory word, delay in the upper half
    typedef struct packed {
        logic [fieldWidth-1:0] delay;
        logic [fieldWidth-1:0] value;
    } sampleT;

    // samples in and out of the buffer
    typedef struct packed {
        logic [countWidth-1:0] received;
        logic [countWidth-1:0] sent;
    } bufferCountsT;

    // wait after the buffer goes non-empty
    localparam int startupDelay = 50000;
    // refill interrupt suppression after a clear
    localparam int holdoffCycles = 50;
    localparam int holdoffWidth = 8;

    typedef enum logic [1:0] {pbIdle, pbPrime, pbFetch, pbHold} playStateT;

endpackage

// ==== common/radiationRegPkg.sv ====
// host command opcodes, command struct
// and register widths
package radiationRegPkg;

    //****************************************
    // widths
    //****************************************

    // one host data word
    localparam int regDataWidth = 32;

    // refill threshold register
    localparam int loadFloorWidth = 16;

    //****************************************
    // host commands
    //****************************************

    // single-cycle register commands from the cpu
    typedef enum logic [2:0] {
        opStartReceiving,
        opLoadFloor,
        opClearRequest,
        opPushSample,
        opProcessingFinished
    } regOpT;

    // one command, valid for exactly one cycle
    typedef struct packed {
        logic                    valid;
        regOpT                   op;
        logic [regDataWidth-1:0] data;
    } regCmdT;

endpackage

// ==== logic/hostRegisters.sv ====
// host command decoder
// registered command pulses and load floor register
module hostRegisters (
    input  logic                                        clk,
    input  logic                                        reset,
    input  radiationRegPkg::regCmdT                     cmd,
    output logic                                        pushStrobe,
    output radiationBufferPkg::sampleT                  pushData,
    output logic                                        startPulse,
    output logic                                        clearPulse,
    output logic                                        finishedPulse,
    output logic [radiationRegPkg::loadFloorWidth-1:0]  loadFloor
);
    import radiationRegPkg::*;
    import radiationBufferPkg::*;

    // opcode matches, only for a valid command
    logic isPush;
    logic isStart;
    logic isClear;
    logic isFinished;
    logic isFloor;

    assign isPush = cmd.valid && (cmd.op == opPushSample);
    assign isStart = cmd.valid && (cmd.op == opStartReceiving);
    assign isClear = cmd.valid && (cmd.op == opClearRequest);
    assign isFinished = cmd.valid && (cmd.op == opProcessingFinished);
    assign isFloor = cmd.valid && (cmd.op == opLoadFloor);

    //****************************************
    // command pulses
    //****************************************

    // every pulse lasts one cycle, one cycle after its command
    always_ff @(posedge clk) begin
        if (!reset) begin
            pushStrobe <= 1'b0;
            startPulse <= 1'b0;
            clearPulse <= 1'b0;
            finishedPulse <= 1'b0;
        end else begin
            pushStrobe <= isPush;
            startPulse <= isStart;
            clearPulse <= isClear;
            finishedPulse <= isFinished;
        end
    end

    // sample word travels with pushStrobe
    always_ff @(posedge clk) begin
        if (isPush) begin
            pushData <= sampleT'(cmd.data);
        end
    end

    //****************************************
    // load floor
    //****************************************

    // low half of the data word is the threshold
    always_ff @(posedge clk) begin
        if (!reset) begin
            loadFloor <= '0;
        end else if (isFloor) begin
            loadFloor <= cmd.data[loadFloorWidth-1:0];
        end
    end

endmodule

// ==== logic/processingTimer.sv ====
// host processing timer
// runs from valueReady rising until processingFinished
module processingTimer (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        valueReady,
    input  logic                                        finishedPulse,
    output logic [radiationBufferPkg::countWidth-1:0]   radiationTimer
);
    // valueReady one cycle back
    logic prevValueReady;
    logic readyRise;

    assign readyRise = valueReady && !prevValueReady;

    always_ff @(posedge clk) begin
        if (!reset) begin
            prevValueReady <= 1'b0;
        end else begin
            prevValueReady <= valueReady;
        end
    end

    // start at 1, count while running, stop on finished
    always_ff @(posedge clk) begin
        if (!reset) begin
            radiationTimer <= '0;
        end else if (readyRise) begin
            radiationTimer <= 1;
        end else if (finishedPulse) begin
            radiationTimer <= '0;
        end else if (radiationTimer != '0) begin
            radiationTimer <= radiationTimer + 1'b1;
        end
    end

endmodule

// ==== logic/radiationProcessor.sv ====
// radiation sample playback engine top level
module radiationProcessor (
    input  logic                                        clk,
    input  logic                                        reset,
    input  radiationRegPkg::regCmdT                     cmd,
    output logic                                        valueReady,
    output logic [radiationBufferPkg::valueWidth-1:0]   radiationValue,
    output logic                                        requestEthernetValues,
    output radiationBufferPkg::bufferCountsT            counts,
    output logic [radiationBufferPkg::countWidth-1:0]   radiationTimer
);
    // decoded host pulses
    logic pushStrobe;
    logic startPulse;
    logic clearPulse;
    logic finishedPulse;
    radiationBufferPkg::sampleT pushData;
    logic [radiationRegPkg::loadFloorWidth-1:0] loadFloor;

    // buffer to scheduler
    logic readStrobe;
    logic sampleAvailable;
    radiationBufferPkg::sampleT sample;

    //****************************************
    // blocks
    //****************************************

    hostRegisters u_hostRegisters (
        .clk          (clk),
        .reset        (reset),
        .cmd          (cmd),
        .pushStrobe   (pushStrobe),
        .pushData     (pushData),
        .startPulse   (startPulse),
        .clearPulse   (clearPulse),
        .finishedPulse(finishedPulse),
        .loadFloor    (loadFloor)
    );

    // received half of counts comes from the buffer
    sampleBuffer u_sampleBuffer (
        .clk            (clk),
        .reset          (reset),
        .pushStrobe     (pushStrobe),
        .pushData       (pushData),
        .readStrobe     (readStrobe),
        .sample         (sample),
        .sampleAvailable(sampleAvailable),
        .received       (counts.received)
    );

    // sent half of counts comes from the scheduler
    playbackScheduler u_playbackScheduler (
        .clk            (clk),
        .reset          (reset),
        .sampleAvailable(sampleAvailable),
        .sample         (sample),
        .finishedPulse  (finishedPulse),
        .readStrobe     (readStrobe),
        .radiationValue (radiationValue),
        .valueReady     (valueReady),
        .sent           (counts.sent)
    );

    refillRequester u_refillRequester (
        .clk                  (clk),
        .reset                (reset),
        .received             (counts.received),
        .sent                 (counts.sent),
        .loadFloor            (loadFloor),
        .startPulse           (startPulse),
        .clearPulse           (clearPulse),
        .requestEthernetValues(requestEthernetValues)
    );

    processingTimer u_processingTimer (
        .clk           (clk),
        .reset         (reset),
        .valueReady    (valueReady),
        .finishedPulse (finishedPulse),
        .radiationTimer(radiationTimer)
    );

endmodule

// ==== logic/refillRequester.sv ====
// refill interrupt from buffer occupancy
// with hold-off after a host clear
module refillRequester (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [radiationBufferPkg::countWidth-1:0]   received,
    input  logic [radiationBufferPkg::countWidth-1:0]   sent,
    input  logic [radiationRegPkg::loadFloorWidth-1:0]  loadFloor,
    input  logic                                        startPulse,
    input  logic                                        clearPulse,
    output logic                                        requestEthernetValues
);
    import radiationBufferPkg::*;

    // samples still waiting in the buffer
    logic [countWidth-1:0] occupancy;
    // buffer at or under the host threshold
    logic lowBuffer;
    // suppression window after a clear
    logic [holdoffWidth-1:0] holdoff;

    assign occupancy = received - sent;
    assign lowBuffer = (received != '0) && (occupancy <= countWidth'(loadFloor));

    //****************************************
    // hold-off counter
    //****************************************

    always_ff @(posedge clk) begin
        if (!reset) begin
            holdoff <= '0;
        end else if (clearPulse) begin
            holdoff <= holdoffWidth'(holdoffCycles);
        end else if (holdoff != '0) begin
            holdoff <= holdoff - 1'b1;
        end
    end

    //****************************************
    // refill interrupt
    //****************************************

    // sticky until the host clears it
    always_ff @(posedge clk) begin
        if (!reset) begin
            requestEthernetValues <= 1'b0;
        end else if (clearPulse) begin
            requestEthernetValues <= 1'b0;
        end else if ((holdoff == '0) && (lowBuffer || startPulse)) begin
            requestEthernetValues <= 1'b1;
        end
    end

endmodule

// ==== playback/playbackScheduler.sv ====
// playback FSM with startup delay and per-sample delay countdown,
// valueReady interrupt and sent counter
module playbackScheduler (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        sampleAvailable,
    input  radiationBufferPkg::sampleT                  sample,
    input  logic                                        finishedPulse,
    output logic                                        readStrobe,
    output logic [radiationBufferPkg::valueWidth-1:0]   radiationValue,
    output logic                                        valueReady,
    output logic [radiationBufferPkg::countWidth-1:0]   sent
);
    import radiationBufferPkg::*;

    playStateT state;

    // shared by startup wait and sample delay
    logic [fieldWidth-1:0] countdown;
    logic countDone;

    assign countDone = (countdown == '0);

    // memory read request
    // prime end always has a sample, hold end only if one is waiting
    assign readStrobe = ((state == pbPrime) && countDone)
                     || ((state == pbHold) && countDone && sampleAvailable);

    //****************************************
    // state machine
    //****************************************

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= pbIdle;
            countdown <= '0;
        end else begin
            unique case (state)
                pbIdle: begin
                    // buffer just went non-empty
                    if (sampleAvailable) begin
                        state <= pbPrime;
                        countdown <= fieldWidth'(startupDelay - 1);
                    end
                end
                pbPrime: begin
                    if (countDone) begin
                        state <= pbFetch;
                    end else begin
                        countdown <= countdown - 1'b1;
                    end
                end
                pbFetch: begin
                    // sample from memory is valid here
                    countdown <= sample.delay;
                    state <= pbHold;
                end
                pbHold: begin
                    if (!countDone) begin
                        countdown <= countdown - 1'b1;
                    end else if (sampleAvailable) begin
                        state <= pbFetch;
                    end else begin
                        state <= pbIdle;
                    end
                end
                default: state <= pbIdle;
            endcase
        end
    end

    //****************************************
    // value output
    //****************************************

    // latch value, raise interrupt, count the send
    // new value wins over a finished pulse in the same cycle
    always_ff @(posedge clk) begin
        if (!reset) begin
            radiationValue <= '0;
            valueReady <= 1'b0;
            sent <= '0;
        end else if (state == pbFetch) begin
            radiationValue <= sample.value[valueWidth-1:0];
            valueReady <= 1'b1;
            sent <= sent + 1'b1;
        end else if (finishedPulse) begin
            valueReady <= 1'b0;
        end
    end

endmodule

// ==== playback/sampleBuffer.sv ====
// sample buffer with inferred dual-port memory,
// write and read pointers and the received counter
module sampleBuffer (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        pushStrobe,
    input  radiationBufferPkg::sampleT                  pushData,
    input  logic                                        readStrobe,
    output radiationBufferPkg::sampleT                  sample,
    output logic                                        sampleAvailable,
    output logic [radiationBufferPkg::countWidth-1:0]   received
);
    import radiationBufferPkg::*;

    //****************************************
    // storage
    //****************************************

    // port a writes, port b reads
    sampleT sampleMem [bufferDepth];

    // next free slot
    logic [bufferAddrWidth-1:0] wrPtr;
    // next sample to play
    logic [bufferAddrWidth-1:0] rdPtr;

    // write port
    always_ff @(posedge clk) begin
        if (pushStrobe) begin
            sampleMem[wrPtr] <= pushData;
        end
    end

    // read port
    // one cycle of latency, data valid after readStrobe
    always_ff @(posedge clk) begin
        if (readStrobe) begin
            sample <= sampleMem[rdPtr];
        end
    end

    //****************************************
    // pointers
    //****************************************

    // write pointer moves with each pushed sample
    // wraps at bufferDepth, overflow not detected
    always_ff @(posedge clk) begin
        if (!reset) begin
            wrPtr <= '0;
        end else if (pushStrobe) begin
            wrPtr <= wrPtr + 1'b1;
        end
    end

    // read pointer moves with each fetch
    always_ff @(posedge clk) begin
        if (!reset) begin
            rdPtr <= '0;
        end else if (readStrobe) begin
            rdPtr <= rdPtr + 1'b1;
        end
    end

    // something left to play
    assign sampleAvailable = (rdPtr != wrPtr);

    //****************************************
    // intake counter
    //****************************************

    // counts every accepted sample
    // same edge as the memory write
    always_ff @(posedge clk) begin
        if (!reset) begin
            received <= '0;
        end else if (pushStrobe) begin
            received <= received + 1'b1;
        end
    end

endmodule

// ==== radiationProcessor.f ====
common/radiationRegPkg.sv
common/radiationBufferPkg.sv
logic/hostRegisters.sv
playback/sampleBuffer.sv
playback/playbackScheduler.sv
logic/refillRequester.sv
logic/processingTimer.sv
logic/radiationProcessor.sv
verif/radiationProcessor_assert.sv
verif/radiationProcessorTb.sv

// ==== verif/radiationProcessorTb.sv ====
// testbench for the playback engine
// clock, reset, host command stimulus, watchdog and closing report
module radiationProcessorTb;
    import radiationRegPkg::*;
    import radiationBufferPkg::*;

    localparam int driveDelay = 5;
    localparam int sampleCount = 9;

    logic clk;
    logic reset;
    regCmdT cmd;
    logic valueReady;
    logic [valueWidth-1:0] radiationValue;
    logic requestEthernetValues;
    bufferCountsT counts;
    logic [countWidth-1:0] radiationTimer;

    sampleT stimulus [sampleCount];
    int watchdogCycles = 0;
    int timeoutCount = 0;

    radiationProcessor u_radiationProcessor (
        .clk                  (clk),
        .reset                (reset),
        .cmd                  (cmd),
        .valueReady           (valueReady),
        .radiationValue       (radiationValue),
        .requestEthernetValues(requestEthernetValues),
        .counts               (counts),
        .radiationTimer       (radiationTimer)
    );

    bind radiationProcessor radiationProcessor_assert u_assert (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //****************************************
    // helpers
    //****************************************

    // called just after an edge, command lasts one cycle
    task automatic issueCommand(input regOpT op, input logic [regDataWidth-1:0] data);
        cmd = '{valid: 1'b1, op: op, data: data};
        @(posedge clk);
        #driveDelay;
        cmd.valid = 1'b0;
    endtask

    // host side of the interrupt
    task automatic acknowledgeValues(input int count);
        int waitCycles;
        for (int i = 0; i < count; i++) begin
            while (!valueReady) begin
                @(posedge clk);
                #driveDelay;
            end
            // short enough to finish before the next send
            waitCycles = $urandom_range(3, 1);
            repeat (waitCycles) @(posedge clk);
            #driveDelay;
            issueCommand(opProcessingFinished, '0);
            @(posedge clk);
            #driveDelay;
        end
    endtask

    task automatic reportAndStop();
        int assertErrors;
        assertErrors = u_radiationProcessor.u_assert.failCount;
        $display("errors: %0d assertion failures, %0d timeouts", assertErrors, timeoutCount);
        if (assertErrors == 0 && timeoutCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    //****************************************
    // stimulus
    //****************************************

    initial begin
        int delaySum;
        reset = 1'b0;
        cmd = '0;
        delaySum = 0;
        void'($urandom(32'h517461c1));
        for (int i = 0; i < sampleCount; i++) begin
            stimulus[i].value = 16'($urandom);
            stimulus[i].delay = 16'($urandom_range(60, 5));
            delaySum += stimulus[i].delay;
        end
        // two startup waits, every delay, ack overhead per sample
        watchdogCycles = 2 * startupDelay + delaySum + sampleCount * 12 + 1000;

        repeat (8) @(posedge clk);
        #driveDelay;
        reset = 1'b1;
        @(posedge clk);
        #driveDelay;

        issueCommand(opLoadFloor, 32'd2);
        issueCommand(opStartReceiving, '0);
        for (int i = 0; i < 6; i++) begin
            issueCommand(opPushSample, stimulus[i]);
        end
        issueCommand(opClearRequest, '0);
        acknowledgeValues(6);

        // buffer drained, refill request comes back
        while (!requestEthernetValues) begin
            @(posedge clk);
            #driveDelay;
        end

        // clear while the buffer is still low
        // request may only return after the hold-off
        issueCommand(opClearRequest, '0);
        @(posedge clk);
        #driveDelay;
        while (!requestEthernetValues) begin
            @(posedge clk);
            #driveDelay;
        end

        for (int i = 6; i < sampleCount; i++) begin
            issueCommand(opPushSample, stimulus[i]);
        end
        issueCommand(opClearRequest, '0);
        acknowledgeValues(3);

        repeat (4) @(posedge clk);
        #driveDelay;
        reportAndStop();
    end

    // watchdog
    initial begin
        wait (watchdogCycles != 0);
        repeat (watchdogCycles) @(posedge clk);
        $display("timeout: playback did not complete within %0d cycles", watchdogCycles);
        timeoutCount = 1;
        reportAndStop();
    end

endmodule

// ==== verif/radiationProcessor_assert.sv ====
// bound checker for the playback engine
// reference sample store and concurrent assertions
module radiationProcessor_assert (
    input  logic                                        clk,
    input  logic                                        reset,
    input  radiationRegPkg::regCmdT                     cmd,
    input  logic                                        valueReady,
    input  logic [radiationBufferPkg::valueWidth-1:0]   radiationValue,
    input  logic                                        requestEthernetValues,
    input  radiationBufferPkg::bufferCountsT            counts,
    input  logic [radiationBufferPkg::countWidth-1:0]   radiationTimer
);
    import radiationRegPkg::*;
    import radiationBufferPkg::*;

    // host commands seen on the bus
    logic isPush;
    logic isStart;
    logic isClear;
    logic isFinished;
    logic isFloor;
    // samples in push order
    sampleT pushedSample [256];
    logic [7:0] pushIdx;
    logic [7:0] sentIdx;
    // load floor as the host wrote it
    logic [loadFloorWidth-1:0] floorRef;
    logic lowRef;
    // cycles since the last clear, saturating
    logic [15:0] sinceClear;
    // spacing between sends
    logic [countWidth-1:0] prevSent;
    logic sentStep;
    logic [15:0] gapCount;
    logic [fieldWidth-1:0] lastDelay;
    logic havePrev;
    logic started;
    logic allIdle;
    int failCount = 0;

    assign isPush = cmd.valid && (cmd.op == opPushSample);
    assign isStart = cmd.valid && (cmd.op == opStartReceiving);
    assign isClear = cmd.valid && (cmd.op == opClearRequest);
    assign isFinished = cmd.valid && (cmd.op == opProcessingFinished);
    assign isFloor = cmd.valid && (cmd.op == opLoadFloor);

    assign sentIdx = counts.sent[7:0] - 8'd1;
    assign sentStep = (counts.sent != prevSent);
    assign lowRef = (counts.received != '0)
                 && ((counts.received - counts.sent) <= countWidth'(floorRef));
    assign allIdle = !valueReady && !requestEthernetValues
                  && (counts == '0) && (radiationTimer == '0);

    //****************************************
    // reference models
    //****************************************

    // first clock edge has gone by
    always_ff @(posedge clk) begin
        started <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            pushIdx <= '0;
            floorRef <= '0;
            sinceClear <= '1;
        end else begin
            if (isPush) begin
                pushedSample[pushIdx] <= sampleT'(cmd.data);
                pushIdx <= pushIdx + 8'd1;
            end
            if (isFloor) begin
                floorRef <= cmd.data[loadFloorWidth-1:0];
            end
            if (isClear) begin
                sinceClear <= '0;
            end else if (sinceClear != '1) begin
                sinceClear <= sinceClear + 16'd1;
            end
        end
    end

    // gap counter restarts on each send
    always_ff @(posedge clk) begin
        if (!reset) begin
            prevSent <= '0;
            gapCount <= '0;
            lastDelay <= '0;
            havePrev <= 1'b0;
        end else begin
            prevSent <= counts.sent;
            if (sentStep) begin
                gapCount <= 16'd1;
                lastDelay <= pushedSample[sentIdx].delay;
                havePrev <= 1'b1;
            end else if (gapCount != '1) begin
                gapCount <= gapCount + 16'd1;
            end
        end
    end

    //****************************************
    // assertions
    //****************************************

    resetIdle: assert property (@(posedge clk)
        started && $past(!reset) |-> allIdle)
    else begin
        failCount = failCount + 1;
        $error("ERROR %0t: outputs not zero around reset", $time);
    end

    // two cycles from command to counter
    intakeCount: assert property (@(posedge clk) disable iff (!reset)
        counts.received == $past(counts.received) + ($past(isPush, 2) ? 32'd1 : 32'd0))
    else begin
        failCount = failCount + 1;
        $error("ERROR %0t: received count %0d unexpected", $time, counts.received);
    end

    sendInOrder: assert property (@(posedge clk) disable iff (!reset)
        sentStep |-> valueReady && (counts.sent == prevSent + 1)
            && (radiationValue == pushedSample[sentIdx].value[valueWidth-1:0]))
    else begin
        failCount = failCount + 1;
        $error("ERROR %0t: send %0d has value %0h", $time, counts.sent, radiationValue);
    end

    sendSpacing: assert property (@(posedge clk) disable iff (!reset)
        sentStep && havePrev |-> gapCount >= lastDelay + 2)
    else begin
        failCount = failCount + 1;
        $error("ERROR %0t: send after %0d cycles, delay %0d", $time, gapCount, lastDelay);
    end

    clearDrops: assert property (@(posedge clk) disable iff (!reset)
        $past(isClear, 2) |-> !requestEthernetValues)
    else begin
        failCount = failCount + 1;
        $error("ERROR %0t: refill request high after clear", $time);
    end

    holdoffKept: assert property (@(posedge clk) disable iff (!reset)
        $rose(requestEthernetValues) |-> sinceClear >= holdoffCycles)
    else begin
        failCount = failCount + 1;
        $error("ERROR %0t: refill request inside hold-off window", $time);
    end

    // low buffer or a fresh start
    riseCause: assert property (@(posedge clk) disable iff (!reset)
        $rose(requestEthernetValues) |-> $past(lowRef) || $past(isStart, 2))
    else begin
        failCount = failCount + 1;
        $error("ERROR %0t: refill request without cause", $time);
    end

    timerStart: assert property (@(posedge clk) disable iff (!reset)
        $rose(valueReady) |=> radiationTimer == 1)
    else begin
        failCount = failCount + 1;
        $error("ERROR %0t: timer %0d after valueReady rise", $time, radiationTimer);
    end

    timerRuns: assert property (@(posedge clk) disable iff (!reset)
        $past(valueReady) && $past(valueReady, 2) && !$past(isFinished, 2)
            |-> radiationTimer == $past(radiationTimer) + 1)
    else begin
        failCount = failCount + 1;
        $error("ERROR %0t: timer %0d did not advance", $time, radiationTimer);
    end

    finishClears: assert property (@(posedge clk) disable iff (!reset)
        $past(isFinished, 2) |-> (radiationTimer == '0) && !valueReady)
    else begin
        failCount = failCount + 1;
        $error("ERROR %0t: timer or valueReady not cleared", $time);
    end

endmodule
